/* hdl/seqswitch_pkg.sv */
// ####################################################################
// Sequential switch shared types.
// Sample, jack and routing definitions used by the whole block.
// ####################################################################

package seqswitch_pkg;

    // Calibrated sample in millivolts.
    // Signed, 16 bits, the low 2 bits are fractional.
    typedef logic signed [15:0] sample_t;

    // Jack-detect word from the surrounding hardware.
    // Bit n is high when channel n has a cable patched in.
    typedef logic [7:0] jack_t;

    // One sample per channel, refreshed every sample clock.
    // Channel 0 sits in the low bits.
    typedef struct packed {
        sample_t ch3;
        sample_t ch2;
        sample_t ch1;
        sample_t ch0;
    } sample_quad_t;

    // Routing state of the switch.
    // Outputs 1, 2, 3 take inputs 1, 2, 3 in STRAIGHT.
    // Outputs 1, 2, 3 take inputs 2, 3, 1 in SHIFT1.
    // Outputs 1, 2, 3 take inputs 3, 1, 2 in SHIFT2.
    typedef enum logic [1:0] {
        ROUTE_STRAIGHT = 2'd0,
        ROUTE_SHIFT1   = 2'd1,
        ROUTE_SHIFT2   = 2'd2
    } route_t;

    // Number of fractional bits in a sample.
    // Millivolt values are shifted left by this to get sample units.
    localparam int FP_OFFSET = 2;

    // Jack-detect bit of the clock input.
    localparam int CLOCK_JACK = 0;

endpackage

/* hdl/seqswitch_clock_decode.sv */
// ####################################################################
// Clock decode for the sequential switch.
// Schmitt trigger on channel 0 with hysteresis, gated by the clock
// jack, giving a registered one-cycle pulse on each rising edge.
// ####################################################################

module seqswitch_clock_decode #(
    parameter int schmitt_hi_mv = 2000,
    parameter int schmitt_lo_mv = 500
) (
    input  logic                   sample_clk,
    input  logic                   rst,
    input  seqswitch_pkg::sample_t trigger,
    input  seqswitch_pkg::jack_t   jack,
    output logic                   edge_pulse
);

    // Thresholds converted from millivolts to sample units.
    localparam seqswitch_pkg::sample_t schmitt_hi =
        seqswitch_pkg::sample_t'(schmitt_hi_mv <<< seqswitch_pkg::FP_OFFSET);
    localparam seqswitch_pkg::sample_t schmitt_lo =
        seqswitch_pkg::sample_t'(schmitt_lo_mv <<< seqswitch_pkg::FP_OFFSET);

    // Registered trigger level.
    logic level;

    // Clock cable present.
    logic jack_patched;

    // Crossing conditions, both signed compares.
    logic rise;
    logic fall;

    assign jack_patched = jack[seqswitch_pkg::CLOCK_JACK];

    // Low to high needs a value strictly above the high threshold.
    assign rise = !level && (trigger > schmitt_hi);

    // High to low needs a value strictly below the low threshold.
    // Values in between keep the current level.
    assign fall = level && (trigger < schmitt_lo);

    always_ff @(posedge sample_clk) begin
        if (rst) begin
            level      <= 1'b0;
            edge_pulse <= 1'b0;
        end else if (!jack_patched) begin
            // No cable, so history is dropped.
            // Patching later starts again from a low level.
            level      <= 1'b0;
            edge_pulse <= 1'b0;
        end else begin
            // Pulse lasts for the one cycle after the crossing.
            edge_pulse <= rise;
            if (rise) begin
                level <= 1'b1;
            end else if (fall) begin
                level <= 1'b0;
            end
        end
    end

endmodule

/* hdl/seqswitch_step.sv */
// ####################################################################
// Routing state machine for the sequential switch.
// Steps STRAIGHT, SHIFT1, SHIFT2 and back, one step per edge pulse.
// ####################################################################

module seqswitch_step (
    input  logic                  sample_clk,
    input  logic                  rst,
    input  logic                  edge_pulse,
    output seqswitch_pkg::route_t route
);

    // Current and next routing state.
    seqswitch_pkg::route_t state;
    seqswitch_pkg::route_t state_next;

    // Next-state logic.
    // Without a pulse every legal state holds.
    always_comb begin
        case (state)
            seqswitch_pkg::ROUTE_STRAIGHT: begin
                state_next = edge_pulse ? seqswitch_pkg::ROUTE_SHIFT1
                                        : seqswitch_pkg::ROUTE_STRAIGHT;
            end
            seqswitch_pkg::ROUTE_SHIFT1: begin
                state_next = edge_pulse ? seqswitch_pkg::ROUTE_SHIFT2
                                        : seqswitch_pkg::ROUTE_SHIFT1;
            end
            seqswitch_pkg::ROUTE_SHIFT2: begin
                // Wrap after the third state.
                state_next = edge_pulse ? seqswitch_pkg::ROUTE_STRAIGHT
                                        : seqswitch_pkg::ROUTE_SHIFT2;
            end
            default: begin
                // Unused encoding, fall back to straight routing.
                state_next = seqswitch_pkg::ROUTE_STRAIGHT;
            end
        endcase
    end

    // State register.
    // It moves on the clock edge where the pulse is high.
    always_ff @(posedge sample_clk) begin
        if (rst) begin
            state <= seqswitch_pkg::ROUTE_STRAIGHT;
        end else begin
            state <= state_next;
        end
    end

    assign route = state;

endmodule

/* hdl/seqswitch_route.sv */
// ####################################################################
// Registered 3x3 crossbar for the sequential switch.
// Places inputs 1 to 3 on outputs 1 to 3 as the routing state says.
// ####################################################################

module seqswitch_route (
    input  logic                        sample_clk,
    input  logic                        rst,
    input  seqswitch_pkg::route_t       route,
    input  seqswitch_pkg::sample_quad_t samples_in,
    output seqswitch_pkg::sample_quad_t switched
);

    // Crossbar selection ahead of the output register.
    seqswitch_pkg::sample_quad_t selected;

    always_comb begin
        // Channel 0 is not switched here, it stays zero.
        selected = '0;
        case (route)
            seqswitch_pkg::ROUTE_SHIFT1: begin
                // Outputs take inputs 2, 3, 1.
                selected.ch1 = samples_in.ch2;
                selected.ch2 = samples_in.ch3;
                selected.ch3 = samples_in.ch1;
            end
            seqswitch_pkg::ROUTE_SHIFT2: begin
                // Outputs take inputs 3, 1, 2.
                selected.ch1 = samples_in.ch3;
                selected.ch2 = samples_in.ch1;
                selected.ch3 = samples_in.ch2;
            end
            default: begin
                // Straight through.
                // Also covers encodings the step FSM never produces.
                selected.ch1 = samples_in.ch1;
                selected.ch2 = samples_in.ch2;
                selected.ch3 = samples_in.ch3;
            end
        endcase
    end

    // Output register, one cycle of latency on the sample path.
    // Uses the route held just before the clock edge.
    always_ff @(posedge sample_clk) begin
        if (rst) begin
            switched <= '0;
        end else begin
            switched <= selected;
        end
    end

endmodule

/* hdl/seqswitch_top.sv */
// ####################################################################
// Sequential switch top level.
// Clock decode on channel 0 steps the routing of channels 1 to 3.
// ####################################################################

module seqswitch_top #(
    parameter int schmitt_hi_mv = 2000,
    parameter int schmitt_lo_mv = 500
) (
    input  logic                        sample_clk,
    input  logic                        rst,
    input  seqswitch_pkg::sample_quad_t samples_in,
    input  seqswitch_pkg::jack_t        jack,
    output seqswitch_pkg::sample_quad_t samples_out
);

    // One-cycle pulse per rising edge of the trigger.
    logic edge_pulse;

    // Current routing state.
    seqswitch_pkg::route_t route;

    // Registered crossbar output, ch0 field unused.
    seqswitch_pkg::sample_quad_t switched;

    // Schmitt trigger on channel 0.
    seqswitch_clock_decode #(
        .schmitt_hi_mv (schmitt_hi_mv),
        .schmitt_lo_mv (schmitt_lo_mv)
    ) u_decode (
        .sample_clk (sample_clk),
        .rst        (rst),
        .trigger    (samples_in.ch0),
        .jack       (jack),
        .edge_pulse (edge_pulse)
    );

    // Routing FSM.
    seqswitch_step u_step (
        .sample_clk (sample_clk),
        .rst        (rst),
        .edge_pulse (edge_pulse),
        .route      (route)
    );

    // Crossbar for channels 1 to 3.
    seqswitch_route u_route (
        .sample_clk (sample_clk),
        .rst        (rst),
        .route      (route),
        .samples_in (samples_in),
        .switched   (switched)
    );

    // Clock input is mirrored with no latency.
    assign samples_out.ch0 = samples_in.ch0;

    // Switched channels come from the crossbar register.
    assign samples_out.ch1 = switched.ch1;
    assign samples_out.ch2 = switched.ch2;
    assign samples_out.ch3 = switched.ch3;

endmodule

/* tests/seqswitch_sva.sv */
// ####################################################################
// Assertions on the sequential switch routing FSM.
// Checks the edge pulse width and when the routing state may change.
// ####################################################################

module seqswitch_sva (
    input logic                  sample_clk,
    input logic                  rst,
    input logic                  edge_pulse,
    input seqswitch_pkg::route_t route
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures seen so far.
    int failures = 0;

    // Pulse from the decode lasts exactly one cycle.
    a_single_pulse: assert property (
        @(posedge sample_clk) disable iff (rst) edge_pulse |=> !edge_pulse
    ) else begin
        failures++;
        $error("edge pulse stayed high for two cycles");
    end

    // Without a pulse the routing holds.
    a_route_hold: assert property (
        @(posedge sample_clk) disable iff (rst) !edge_pulse |=> $stable(route)
    ) else begin
        failures++;
        $error("route changed without an edge pulse");
    end

    // A pulse always moves the routing on.
    a_route_step: assert property (
        @(posedge sample_clk) disable iff (rst) edge_pulse |=> route != $past(route)
    ) else begin
        failures++;
        $error("route did not advance after an edge pulse");
    end

    // Only the three legal encodings.
    a_route_legal: assert property (
        @(posedge sample_clk) disable iff (rst)
        route inside {seqswitch_pkg::ROUTE_STRAIGHT, seqswitch_pkg::ROUTE_SHIFT1,
                      seqswitch_pkg::ROUTE_SHIFT2}
    ) else begin
        failures++;
        $error("route holds an encoding outside the enum");
    end

endmodule

// The step FSM sees both the decode pulse and the route it drives.
bind seqswitch_step seqswitch_sva u_sva (
    .sample_clk (sample_clk),
    .rst        (rst),
    .edge_pulse (edge_pulse),
    .route      (route)
);

/* tests/seqswitch_check.sv */
// ####################################################################
// Checker for the sequential switch.
// Runs a reference model next to the DUT and compares every cycle.
// ####################################################################

module seqswitch_check #(
    parameter int schmitt_hi_mv = 2000,
    parameter int schmitt_lo_mv = 500
) (
    input  logic                        sample_clk,
    input  logic                        rst,
    input  seqswitch_pkg::jack_t        jack,
    input  seqswitch_pkg::sample_quad_t samples_in,
    input  seqswitch_pkg::sample_quad_t samples_out,
    output int                          errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // Thresholds in sample units, two fraction bits.
    localparam int hi_units = schmitt_hi_mv * 4;
    localparam int lo_units = schmitt_lo_mv * 4;

    // Model state: trigger level, pending pulse, rotation and outputs 1 to 3.
    typedef struct packed {
        logic                   level;
        logic                   pulse;
        logic [1:0]             rot;
        seqswitch_pkg::sample_t out1;
        seqswitch_pkg::sample_t out2;
        seqswitch_pkg::sample_t out3;
    } model_t;

    model_t model;

    // Set once the first reset edge has cleared the DUT registers.
    logic primed;

    // Model state after one clock edge, from the values seen before it.
    function automatic model_t ref_next(model_t cur, logic reset,
                                       seqswitch_pkg::jack_t jk,
                                       seqswitch_pkg::sample_quad_t in);
        model_t nxt;
        seqswitch_pkg::sample_t ins[3];
        int r;
        nxt = cur;
        r = int'(cur.rot);
        ins[0] = in.ch1;
        ins[1] = in.ch2;
        ins[2] = in.ch3;
        if (reset) begin
            nxt = '0;
        end else begin
            // Output n takes input n rotated by the old routing.
            nxt.out1 = ins[r % 3];
            nxt.out2 = ins[(1 + r) % 3];
            nxt.out3 = ins[(2 + r) % 3];
            // Routing steps one place per pulse and wraps after three.
            if (cur.pulse) begin
                nxt.rot = 2'((r + 1) % 3);
            end
            if (!jk[seqswitch_pkg::CLOCK_JACK]) begin
                nxt.level = 1'b0;
                nxt.pulse = 1'b0;
            end else begin
                nxt.pulse = !cur.level && (int'(in.ch0) > hi_units);
                if (nxt.pulse) begin
                    nxt.level = 1'b1;
                end else if (cur.level && (int'(in.ch0) < lo_units)) begin
                    nxt.level = 1'b0;
                end
            end
        end
        return nxt;
    endfunction

    task automatic compare_sample(input string name, input seqswitch_pkg::sample_t actual,
                                  input seqswitch_pkg::sample_t expected);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    initial begin
        errors = 0;
        primed = 1'b0;
        model  = '0;
    end

    // Model advances on the same edge as the DUT.
    always @(posedge sample_clk) begin
        model <= ref_next(model, rst, jack, samples_in);
        if (rst) begin
            primed <= 1'b1;
        end
    end

    // Compare mid-cycle, when inputs and outputs are settled.
    always @(negedge sample_clk) begin
        if (primed) begin
            compare_sample("samples_out.ch0", samples_out.ch0, samples_in.ch0);
            compare_sample("samples_out.ch1", samples_out.ch1, model.out1);
            compare_sample("samples_out.ch2", samples_out.ch2, model.out2);
            compare_sample("samples_out.ch3", samples_out.ch3, model.out3);
        end
    end

endmodule

/* tests/seqswitch_tb.sv */
// ####################################################################
// Testbench for the sequential switch.
// Scripted trigger phases on channel 0 with random audio on 1 to 3.
// ####################################################################

module seqswitch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;

    // One scripted stretch of channel 0.
    // Kind 0 is below 500 mV, 1 between the thresholds, 2 above 2000 mV.
    typedef struct packed {
        logic [1:0]           kind;
        logic [3:0]           len;
        seqswitch_pkg::jack_t jack;
        logic                 rst;
    } seg_t;

    logic                        sample_clk;
    logic                        rst;
    seqswitch_pkg::sample_quad_t samples_in;
    seqswitch_pkg::jack_t        jack;
    seqswitch_pkg::sample_quad_t samples_out;

    seqswitch_pkg::sample_quad_t next_in;
    seg_t                        script[$];
    int                          script_cycles;
    logic                        script_ready;
    int                          mismatch_count;
    int                          total_errors;

    // Mix of crossings, repeated highs and in-between values.
    // Two rising crossings per pass leave the routing off straight between phases.
    int kind_pattern[12] = '{0, 1, 0, 2, 1, 2, 0, 1, 2, 1, 1, 2};

    seqswitch_top #(
        .schmitt_hi_mv (2000),
        .schmitt_lo_mv (500)
    ) dut (
        .sample_clk  (sample_clk),
        .rst         (rst),
        .samples_in  (samples_in),
        .jack        (jack),
        .samples_out (samples_out)
    );

    seqswitch_check #(
        .schmitt_hi_mv (2000),
        .schmitt_lo_mv (500)
    ) u_check (
        .sample_clk  (sample_clk),
        .rst         (rst),
        .jack        (jack),
        .samples_in  (samples_in),
        .samples_out (samples_out),
        .errors      (mismatch_count)
    );

    always #(clk_period / 2) sample_clk = ~sample_clk;

    // Random channel 0 value in sample units for one kind of stretch.
    function automatic seqswitch_pkg::sample_t trigger_value(input logic [1:0] kind);
        int v;
        case (kind)
            2'd0:    v = int'($urandom_range(0, 2999)) - 1000;
            2'd1:    v = int'($urandom_range(2000, 8000));
            default: v = int'($urandom_range(8001, 20000));
        endcase
        return seqswitch_pkg::sample_t'(v);
    endfunction

    // Appends the pattern reps times, with a reset on the first stretch if asked.
    task automatic add_phase(input seqswitch_pkg::jack_t jk, input logic with_reset,
                             input int reps);
        seg_t seg;
        for (int r = 0; r < reps; r++) begin
            for (int i = 0; i < 12; i++) begin
                seg.kind = 2'(kind_pattern[i]);
                seg.len  = 4'($urandom_range(1, 6));
                seg.jack = jk;
                seg.rst  = with_reset && (r == 0) && (i == 0);
                script.push_back(seg);
                script_cycles += int'(seg.len);
            end
        end
    endtask

    initial begin
        void'($urandom(64));
        sample_clk    = 1'b0;
        rst           = 1'b1;
        samples_in    = '0;
        jack          = 8'hFF;
        script_cycles = 0;
        script_ready  = 1'b0;
        add_phase(8'hFF, 1'b0, 2);
        // Clock cable pulled while the other jacks stay patched.
        add_phase(8'hFE, 1'b0, 1);
        add_phase(8'h01, 1'b0, 2);
        add_phase(8'hFF, 1'b1, 1);
        add_phase(8'h00, 1'b0, 1);
        add_phase(8'hFF, 1'b0, 1);
        script_ready = 1'b1;
        repeat (reset_cycles) @(posedge sample_clk);
        rst <= 1'b0;
        foreach (script[s]) begin
            repeat (script[s].len) begin
                @(posedge sample_clk);
                next_in.ch0 = trigger_value(script[s].kind);
                next_in.ch1 = seqswitch_pkg::sample_t'($urandom);
                next_in.ch2 = seqswitch_pkg::sample_t'($urandom);
                next_in.ch3 = seqswitch_pkg::sample_t'($urandom);
                samples_in <= next_in;
                jack       <= script[s].jack;
                rst        <= script[s].rst;
            end
        end
        @(posedge sample_clk);
        rst <= 1'b0;
        repeat (4) @(posedge sample_clk);
        total_errors = mismatch_count + dut.u_step.u_sva.failures;
        $display("Checks done: %0d mismatches, %0d assertion failures",
                 mismatch_count, dut.u_step.u_sva.failures);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the script length.
    initial begin
        wait (script_ready === 1'b1);
        #((script_cycles + reset_cycles + 100) * clk_period);
        $display("Timeout: the stimulus did not complete in the expected time");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* files.f */
hdl/seqswitch_pkg.sv
hdl/seqswitch_clock_decode.sv
hdl/seqswitch_step.sv
hdl/seqswitch_route.sv
hdl/seqswitch_top.sv
tests/seqswitch_sva.sv
tests/seqswitch_check.sv
tests/seqswitch_tb.sv
